//--- logic/flitFifo.sv
`timescale 1ns/1ns

module flitFifo
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  inValid,
  output logic  inReady,
  input  flit_t inFlit,
  output logic  bufValid,
  input  logic  bufReady,
  output flit_t bufFlit
);

  localparam int ptrWidth = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

  typedef logic [ptrWidth-1:0] ptr_t;
  typedef logic [$clog2(fifoDepth+1)-1:0] count_t;

  flit_t  mem [fifoDepth];
  ptr_t   wrPtr;
  ptr_t   rdPtr;
  count_t count;
  logic   wrEn;
  logic   rdEn;

  function automatic ptr_t nextPtr(ptr_t p);
    if (p == ptr_t'(fifoDepth - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign wrEn     = inValid && inReady;
  assign rdEn     = bufValid && bufReady;
  assign bufValid = (count != '0);
  assign bufFlit  = mem[rdPtr];   // Head of queue

  always_ff @(posedge clk)
  begin
    if (wrEn)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      inReady <= 1'b1;   // Empty after reset
    end
    else
    begin
      if (wrEn)
        wrPtr <= nextPtr(wrPtr);
      if (rdEn)
        rdPtr <= nextPtr(rdPtr);
      case ({wrEn, rdEn})
        2'b10:
        begin
          count   <= count + 1'b1;
          inReady <= (count != count_t'(fifoDepth - 1));
        end
        2'b01:
        begin
          count   <= count - 1'b1;
          inReady <= 1'b1;
        end
        default: ;   // Idle, or write and read together
      endcase
    end
  end

  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
    wrEn |-> (count != count_t'(fifoDepth)))
    else $error("Error %0t: flit accepted into a full buffer", $time);

endmodule

//--- logic/nocPkg.sv
package nocPkg;

  localparam int numPorts = 5;

  // Flit kind, bit 0 marks a head and bit 2 marks a tail
  typedef logic [2:0] flitId_t;
  localparam flitId_t flitHead     = 3'b001;
  localparam flitId_t flitBody     = 3'b010;
  localparam flitId_t flitTail     = 3'b100;
  localparam flitId_t flitHeadTail = 3'b101;

  typedef logic [11:0] pktLen_t;   // Packet length in flits
  typedef logic [18:0] flit_t;     // {flitId_t, 16-bit payload}

  // Port numbers, also the round-robin order
  typedef logic [2:0] portIdx_t;
  localparam portIdx_t portL = 3'd0;
  localparam portIdx_t portN = 3'd1;
  localparam portIdx_t portE = 3'd2;
  localparam portIdx_t portW = 3'd3;
  localparam portIdx_t portS = 3'd4;

  function automatic logic isHead(flit_t f);
    flitId_t id;
    id = f[18:16];
    return |(id & flitHead);
  endfunction

  function automatic logic isTail(flit_t f);
    flitId_t id;
    id = f[18:16];
    return |(id & flitTail);
  endfunction

  function automatic pktLen_t headLen(flit_t f);
    return f[11:0];   // Length sits in the low payload bits
  endfunction

endpackage

//--- logic/outputArbiter.sv
`timescale 1ns/1ns

module outputArbiter
  import nocPkg::*;
#(
  parameter int timerSlack = 2
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     bufValid [numPorts],
  input  flit_t    bufFlit  [numPorts],
  output logic     bufReady [numPorts],
  output logic     outValid,
  input  logic     outReady,
  output flit_t    outFlit,
  output portIdx_t outSrc
);

  typedef enum logic [2:0] {
    ArbIdle,
    GrantL,
    GrantN,
    GrantE,
    GrantW,
    GrantS
  } arbState_t;

  arbState_t state;
  arbState_t nextState;
  portIdx_t  curPort;
  logic      granted;
  logic      stall;
  logic      tailDone;
  logic      holdGrant;

  logic    headSeen   [numPorts];
  pktLen_t headLength [numPorts];
  logic    runTimer   [numPorts];
  logic    timesUp    [numPorts];
  logic [numPorts-1:0] readyVec;

  function automatic arbState_t grantOf(portIdx_t p);
    case (p)
      portL:   return GrantL;
      portN:   return GrantN;
      portE:   return GrantE;
      portW:   return GrantW;
      portS:   return GrantS;
      default: return ArbIdle;
    endcase
  endfunction

  function automatic portIdx_t portOf(arbState_t s);
    case (s)
      GrantN:  return portN;
      GrantE:  return portE;
      GrantW:  return portW;
      GrantS:  return portS;
      default: return portL;   // GrantL, and idle points at L
    endcase
  endfunction

  assign curPort  = portOf(state);
  assign granted  = (state != ArbIdle);
  assign outValid = granted && bufValid[curPort];
  assign outFlit  = bufFlit[curPort];
  assign outSrc   = curPort;

  assign stall    = outValid && !outReady;
  assign tailDone = outValid && outReady && isTail(outFlit);

  // A stalled flit keeps the grant even after the timer expires
  assign holdGrant = stall || (bufValid[curPort] && !timesUp[curPort] && !tailDone);

  for (genvar p = 0; p < numPorts; p++)
  begin : portGen
    assign runTimer[p]   = (state == grantOf(portIdx_t'(p)));
    assign bufReady[p]   = runTimer[p] && outReady;
    assign readyVec[p]   = bufReady[p];
    assign headSeen[p]   = bufReady[p] && bufValid[p] && isHead(bufFlit[p]);
    assign headLength[p] = headLen(bufFlit[p]);

    packetTimer #(
      .timerSlack (timerSlack)
    ) iTimer (
      .clk        (clk),
      .rst        (rst),
      .headSeen   (headSeen[p]),
      .headLength (headLength[p]),
      .runTimer   (runTimer[p]),
      .timesUp    (timesUp[p])
    );
  end

  always_comb
  begin : nextSelect
    int idx;
    nextState = state;
    idx = 0;
    if (state == ArbIdle)
    begin
      // Lowest index wins, so L first
      for (int i = numPorts - 1; i >= 0; i--)
      begin
        if (bufValid[i])
          nextState = grantOf(portIdx_t'(i));
      end
    end
    else if (!holdGrant)
    begin
      // Nearest requester after the current port, the current one excluded
      nextState = ArbIdle;
      for (int k = numPorts - 1; k >= 1; k--)
      begin
        idx = (int'(curPort) + k) % numPorts;
        if (bufValid[idx])
          nextState = grantOf(portIdx_t'(idx));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ArbIdle;
    else
      state <= nextState;
  end

  singleReady: assert property (@(posedge clk) disable iff (rst)
    $onehot0(readyVec))
    else $error("Error %0t: more than one buffer granted", $time);

  stableUnderStall: assert property (@(posedge clk) disable iff (rst)
    stall |=> outValid && $stable(outFlit) && $stable(outSrc))
    else $error("Error %0t: output changed under back-pressure", $time);

endmodule

//--- logic/outputPortSwitch.sv
`timescale 1ns/1ns

module outputPortSwitch
  import nocPkg::*;
#(
  parameter int fifoDepth  = 4,
  parameter int timerSlack = 2
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     inValid [numPorts],
  output logic     inReady [numPorts],
  input  flit_t    inFlit  [numPorts],
  output logic     outValid,
  input  logic     outReady,
  output flit_t    outFlit,
  output portIdx_t outSrc
);

  // Buffer to arbiter links, one per input port
  logic  bufValid [numPorts];
  logic  bufReady [numPorts];
  flit_t bufFlit  [numPorts];

  for (genvar p = 0; p < numPorts; p++)
  begin : bufferGen
    flitFifo #(
      .fifoDepth (fifoDepth)
    ) iFifo (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[p]),
      .inReady  (inReady[p]),
      .inFlit   (inFlit[p]),
      .bufValid (bufValid[p]),
      .bufReady (bufReady[p]),
      .bufFlit  (bufFlit[p])
    );
  end

  outputArbiter #(
    .timerSlack (timerSlack)
  ) iArbiter (
    .clk      (clk),
    .rst      (rst),
    .bufValid (bufValid),
    .bufFlit  (bufFlit),
    .bufReady (bufReady),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

endmodule

//--- logic/packetTimer.sv
`timescale 1ns/1ns

module packetTimer
  import nocPkg::*;
#(
  parameter int timerSlack = 2
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    headSeen,
  input  pktLen_t headLength,
  input  logic    runTimer,
  output logic    timesUp
);

  typedef logic [$bits(pktLen_t):0] limit_t;   // One extra bit for the slack

  pktLen_t lenReg;
  pktLen_t count;
  limit_t  limit;

  assign limit   = limit_t'(lenReg) + limit_t'(timerSlack);
  assign timesUp = (limit_t'(count) >= limit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lenReg <= '0;
      count  <= '0;
    end
    else
    begin
      if (headSeen)
        lenReg <= headLength;
      // Stops at the limit so a stalled port keeps timesUp until it lets go
      if (!runTimer)
        count <= '0;
      else if (!timesUp)
        count <= count + 1'b1;
    end
  end

  // Count creeps up one granted cycle at a time and stops at the budget
  countWithinLimit: assert property (@(posedge clk) disable iff (rst)
    runTimer && $past(runTimer) && $past(limit_t'(count) <= limit) && !$past(headSeen)
      |-> limit_t'(count) <= limit)
    else $error("Error %0t: packet timer passed its limit", $time);

endmodule

//--- verif/outputPortSwitchTb.sv
`timescale 1ns/1ns

module outputPortSwitchTb
  import nocPkg::*;
();

  localparam int fifoDepth  = 4;
  localparam int timerSlack = 2;
  localparam int drainLimit = 3000;   // Cycles allowed for traffic to drain

  logic     clk;
  logic     rst;
  logic     inValid [numPorts];
  logic     inReady [numPorts];
  flit_t    inFlit  [numPorts];
  logic     outValid;
  logic     outReady;
  flit_t    outFlit;
  portIdx_t outSrc;

  flit_t    pendQ [numPorts][$];   // Flits not yet accepted by a buffer
  flit_t    sentQ [numPorts][$];   // Accepted flits still owed at the output
  logic     fire  [numPorts];
  portIdx_t logSrc  [$];
  flit_t    logFlit [$];
  logic [31:0] lfsr;
  int       errCount;
  int       checkCount;
  int       testCount;
  int       errBase;
  int       stallCount;
  int       readyMode;   // 0 ready, 1 random stalls, 2 held low
  logic     timedOut;
  logic     quietPhase;
  logic     contigCheck;
  logic     inPacket;
  portIdx_t ownerPort;

  outputPortSwitch #(
    .fifoDepth  (fifoDepth),
    .timerSlack (timerSlack)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsrNext(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic allEmpty();
    for (int p = 0; p < numPorts; p++)
    begin
      if (pendQ[p].size() != 0 || sentQ[p].size() != 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic reportError(string msg);
    errCount++;
    $display("Error %0t: %s", $time, msg);
  endtask

  // Head carries the claimed length in its low payload bits
  task automatic queuePacket(int port, int nFlits, int claimedLen);
    flit_t   f;
    flitId_t id;
    for (int i = 0; i < nFlits; i++)
    begin
      if (i == 0)
      begin
        id = (nFlits == 1) ? flitHeadTail : flitHead;
        f = {id, 4'(randBits(4)), pktLen_t'(claimedLen)};
      end
      else
      begin
        id = (i == nFlits - 1) ? flitTail : flitBody;
        f = {id, 16'(randBits(16))};
      end
      pendQ[port].push_back(f);
    end
  endtask

  task automatic waitDrain(int limit);
    int cycles;
    cycles = 0;
    while (!allEmpty() && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!allEmpty())
    begin
      timedOut = 1'b1;
      $display("Timeout: traffic did not drain within %0d cycles", limit);
    end
  endtask

  task automatic finishTest(string name);
    testCount++;
    if (timedOut)
      $display("%s test stopped on a timeout", name);
    else
      $display("%s test done with %0d errors", name, errCount - errBase);
  endtask

  task automatic checkOutput(portIdx_t src, flit_t f);
    flit_t expected;
    checkCount++;
    if (src >= numPorts)
      reportError($sformatf("output source %0d is not a port", src));
    else if (sentQ[src].size() == 0)
      reportError($sformatf("port %0d delivered a flit that was never sent", src));
    else
    begin
      expected = sentQ[src].pop_front();
      assert (f == expected)
        else reportError($sformatf("port %0d delivered %h, expected %h", src, f, expected));
      logSrc.push_back(src);
      logFlit.push_back(f);
      if (contigCheck)
      begin
        if (inPacket)
          assert (src == ownerPort)
            else reportError($sformatf("port %0d cut into a packet of port %0d",
                                       src, ownerPort));
        if (f[16])   // Head
        begin
          inPacket  = 1'b1;
          ownerPort = src;
        end
        if (f[18])   // Tail
          inPacket = 1'b0;
      end
    end
  endtask

  task automatic checkHeadOrder(string round);
    portIdx_t heads [$];
    for (int i = 0; i < logFlit.size(); i++)
    begin
      if (logFlit[i][16])
        heads.push_back(logSrc[i]);
    end
    checkCount++;
    assert (heads.size() == numPorts)
      else reportError($sformatf("%s round gave %0d heads", round, heads.size()));
    for (int i = 0; i < heads.size(); i++)
    begin
      if (i < numPorts)
        assert (heads[i] == portIdx_t'(i))
          else reportError($sformatf("%s round head %0d came from port %0d, expected %0d",
                                     round, i, heads[i], i));
    end
  endtask

  // Input handshakes and output checks, sampled mid-cycle
  always @(negedge clk)
  begin
    for (int p = 0; p < numPorts; p++)
    begin
      fire[p] = !rst && inValid[p] && inReady[p];
      if (fire[p])
        sentQ[p].push_back(inFlit[p]);
    end
    if (!rst && outValid && !outReady)
      stallCount++;
    if (!rst && outValid && outReady)
      checkOutput(outSrc, outFlit);
  end

  always @(posedge clk)
  begin : driveInputs
    flit_t dropped;
    #1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (fire[p])
        dropped = pendQ[p].pop_front();
      inValid[p] = (pendQ[p].size() != 0);
      inFlit[p]  = inValid[p] ? pendQ[p][0] : '0;
    end
    case (readyMode)
      0:       outReady = 1'b1;
      1:       outReady = (randBits(2) != 0);   // Stall about one cycle in four
      default: outReady = 1'b0;
    endcase
  end

  resetQuiet: assert property (@(negedge clk)
    quietPhase |-> !outValid && inReady[0] && inReady[1] && inReady[2] && inReady[3]
      && inReady[4])
    else reportError("output active or a buffer not ready while idle");

  stallStable: assert property (@(negedge clk) disable iff (rst)
    (outValid && !outReady) |=> outValid && $stable(outFlit) && $stable(outSrc))
    else reportError("output changed while stalled");

  task automatic runRandomTraffic(string name, int mode, int nPackets);
    int p;
    int len;
    errBase     = errCount;
    readyMode   = mode;
    contigCheck = (mode == 0);
    inPacket    = 1'b0;
    for (int n = 0; n < nPackets; n++)
    begin
      p   = randBits(3) % numPorts;
      len = 1 + randBits(3) % 6;
      queuePacket(p, len, len);
      repeat (randBits(2)) @(posedge clk);
    end
    waitDrain(drainLimit);
    contigCheck = 1'b0;
    readyMode   = 0;
    finishTest(name);
  endtask

  task automatic runRotation();
    int len;
    errBase = errCount;
    for (int round = 0; round < 2; round++)
    begin
      logSrc.delete();
      logFlit.delete();
      for (int p = 0; p < numPorts; p++)
      begin
        len = 1 + randBits(3) % 6;
        queuePacket(p, len, len);
      end
      waitDrain(drainLimit);
      if (timedOut)
        break;
      checkHeadOrder(round == 0 ? "first" : "second");
    end
    finishTest("rotation");
  endtask

  task automatic runBackPressure();
    int stallBase;
    errBase   = errCount;
    stallBase = stallCount;
    readyMode = 2;
    queuePacket(portW, 4, 4);
    queuePacket(portS, 3, 3);
    queuePacket(portL, 2, 2);
    repeat (8) @(posedge clk);
    readyMode = 1;
    repeat (12) @(posedge clk);
    readyMode = 2;
    repeat (5) @(posedge clk);
    readyMode = 0;
    waitDrain(drainLimit);
    checkCount++;
    assert (stallCount > stallBase)
      else reportError("no stalled output cycle was seen");
    finishTest("back-pressure");
  endtask

  task automatic runTimeout();
    int eHead;
    int nTail;
    int nCount;
    errBase = errCount;
    eHead   = -1;
    nTail   = -1;
    nCount  = 0;
    logSrc.delete();
    logFlit.delete();
    queuePacket(portN, 6, 1);   // Head claims one flit, six follow
    queuePacket(portE, 2, 2);
    waitDrain(drainLimit);
    if (!timedOut)
    begin
      for (int i = 0; i < logSrc.size(); i++)
      begin
        if (logSrc[i] == portE && logFlit[i][16] && eHead < 0)
          eHead = i;
        if (logSrc[i] == portN)
        begin
          nCount++;
          if (logFlit[i][18])
            nTail = i;
        end
      end
      checkCount++;
      assert (eHead >= 0 && nTail > eHead)
        else reportError($sformatf("East head at %0d, North tail at %0d", eHead, nTail));
      assert (nCount == 6)
        else reportError($sformatf("North delivered %0d flits, expected 6", nCount));
    end
    finishTest("timeout");
  endtask

  initial
  begin
    rst         = 1'b1;
    outReady    = 1'b1;
    lfsr        = 32'h5bd7;
    errCount    = 0;
    checkCount  = 0;
    testCount   = 0;
    stallCount  = 0;
    readyMode   = 0;
    timedOut    = 1'b0;
    quietPhase  = 1'b0;
    contigCheck = 1'b0;
    inPacket    = 1'b0;
    ownerPort   = portL;
    for (int p = 0; p < numPorts; p++)
    begin
      inValid[p] = 1'b0;
      inFlit[p]  = '0;
      fire[p]    = 1'b0;
    end
    errBase = 0;
    @(posedge clk);
    quietPhase = 1'b1;   // Buffers report ready from the first reset edge
    repeat (9) @(posedge clk);
    #1 rst = 1'b0;
    repeat (5) @(posedge clk);
    quietPhase = 1'b0;
    finishTest("reset");
    runRandomTraffic("integrity", 1, 40);
    if (!timedOut)
      runRandomTraffic("contiguity", 0, 25);
    if (!timedOut)
      runRotation();
    if (!timedOut)
      runBackPressure();
    if (!timedOut)
      runTimeout();
    $display("Tests run: %0d, checks: %0d, errors: %0d", testCount, checkCount, errCount);
    if (errCount == 0 && !timedOut)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- vlog.f
logic/nocPkg.sv
logic/flitFifo.sv
logic/packetTimer.sv
logic/outputArbiter.sv
logic/outputPortSwitch.sv
verif/outputPortSwitchTb.sv
